// ==== tb/exec_cases.txt ====
# name port op rs0 rs1 rd imm(hex, r = random) expected(hex, - = from register model)
# lsu: rs0 is base, rs1 store data; pair: alu0 ADDI loads rs1, then alu1 runs op
add_zero alu0 ADD 5 6 7 0 00000000
ld_r5 alu0 ADDI 0 0 5 0123 00000123
ld_r6 alu1 ADDI 0 0 6 fff0 fffffff0
add_r5_r6 alu0 ADD 5 6 8 0 00000113
sub_r5_r6 alu1 SUB 5 6 9 0 00000133
and_r5_r6 alu0 AND 5 6 10 0 00000120
or_r5_r6 alu1 OR 5 6 11 0 fffffff3
xor_r5_r6 alu0 XOR 5 6 12 0 fffffed3
ld_r13 alu1 ADDI 0 0 13 0024 00000024
sll_masked alu0 SLL 5 13 14 0 00001230
srl_masked alu1 SRL 6 13 15 0 0fffffff
slt_neg alu0 SLT 6 5 16 0 00000001
slt_pos alu1 SLT 5 6 17 0 00000000
addi_neg alu0 ADDI 5 0 18 8000 ffff8123
addi_rand alu1 ADDI 5 0 19 r -
addi_rand2 alu0 ADDI 6 0 20 r -
sub_rand alu1 SUB 19 20 21 0 -
wr_r0 alu0 ADDI 5 0 0 0001 00000124
rd_r0 alu1 ADD 0 0 22 0 00000000
rd_r0_mix alu0 OR 0 5 23 0 00000123
ld_r24 alu0 ADDI 0 0 24 0007 00000007
pair_add pair ADD 5 24 25 0050 00000173
pair_sll pair SLL 5 24 26 0003 00000918
pair_rand pair XOR 5 24 27 r -
ld_r29 alu0 ADDI 0 0 29 1234 00001234
ld_r31 alu1 ADDI 0 0 31 0010 00000010
sll_r30 alu0 SLL 29 31 30 0 12340000
addi_r30 alu1 ADDI 30 0 30 5678 12345678
mul_lo mdu MUL_LO 30 6 32 0 dcba9880
mul_hi mdu MUL_HI 30 6 33 0 12345676
mul_small mdu MUL_LO 5 13 34 0 000028ec
mul_rand mdu MUL_HI 19 6 35 0 -
mul_r0 mdu MUL_LO 0 30 36 0 00000000
st_a lsu STORE 5 30 0 0002 -
ld_a lsu LOAD 5 0 37 0002 12345678
ld_r39 alu0 ADDI 0 0 39 00fa 000000fa
st_wrap lsu STORE 39 6 0 000a -
ld_wrap lsu LOAD 0 0 40 0004 fffffff0
st_neg lsu STORE 39 29 0 fffe -
ld_neg lsu LOAD 0 0 42 00f8 00001234
ld_model lsu LOAD 39 0 43 fffe -

// ==== files.f ====
src/backend_pkg.sv
src/prf.sv
src/alu_pipe.sv
src/mdu_unit.sv
src/lsu_unit.sv
src/exec_cluster.sv
tb/tb_exec_cluster.sv

// ==== Makefile ====
VERILATOR = verilator
VFLAGS    = --binary --timing --timescale 1ns/1ps
TOP       = tb_exec_cluster
FILELIST  = files.f
OBJ_DIR   = obj_dir

SIM     = $(OBJ_DIR)/V$(TOP)
SOURCES = $(shell grep -v '^+' $(FILELIST))

.PHONY: all run clean

all: $(SIM)

$(SIM): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: $(SIM)
	@out="$$(./$(SIM))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "Test OK"

clean:
	rm -rf $(OBJ_DIR)

// ==== tb/tb_exec_cluster.sv ====
`timescale 1ns/1ps

module tb_exec_cluster;
    import backend_pkg::*;

    localparam int PREG_COUNT = 64;
    localparam int DRAM_DEPTH = 256;
    localparam int AW         = $clog2(DRAM_DEPTH);
    localparam int TIMEOUT    = 100;   // Cycles allowed per wait

    logic       clk;
    logic       rst;
    alu_issue_t alu0_issue;
    alu_issue_t alu1_issue;
    logic       mdu_req;
    mdu_issue_t mdu_issue;
    logic       mdu_ack;
    lsu_issue_t lsu_issue;
    wb_info_t   wb_alu0;
    wb_info_t   wb_alu1;
    wb_info_t   wb_mdu;
    wb_info_t   wb_lsu;

    word_t shadow [PREG_COUNT];      // Register model
    word_t mem_model [DRAM_DEPTH];   // Data RAM model
    int    seed = 32'h3fda;
    int    tests;
    int    failed_tests;
    int    test_errs;
    bit    aborted;

    exec_cluster #(
        .PREG_COUNT(PREG_COUNT),
        .DRAM_DEPTH(DRAM_DEPTH)
    ) i_dut (
        .clk        (clk),
        .rst        (rst),
        .alu0_issue (alu0_issue),
        .alu1_issue (alu1_issue),
        .mdu_req    (mdu_req),
        .mdu_issue  (mdu_issue),
        .mdu_ack    (mdu_ack),
        .lsu_issue  (lsu_issue),
        .wb_alu0    (wb_alu0),
        .wb_alu1    (wb_alu1),
        .wb_mdu     (wb_mdu),
        .wb_lsu     (wb_lsu)
    );

    always #2 clk = ~clk;

    function automatic word_t sext16(input logic [15:0] v);
        return {{16{v[15]}}, v};
    endfunction

    function automatic word_t alu_model(input alu_op_e op, input word_t a, input word_t b,
                                        input logic [15:0] imm);
        case (op)
            ADD:  return a + b;
            SUB:  return a - b;
            AND:  return a & b;
            OR:   return a | b;
            XOR:  return a ^ b;
            SLL:  return a << b[4:0];   // Shift amount is five bits
            SRL:  return a >> b[4:0];
            SLT:  return ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
            ADDI: return a + sext16(imm);
            default: return '0;
        endcase
    endfunction

    // Unsigned 64-bit product, low or high word
    function automatic word_t mul_model(input mdu_op_e op, input word_t a, input word_t b);
        logic [63:0] prod;
        prod = {32'b0, a} * {32'b0, b};
        return (op == MUL_HI) ? prod[63:32] : prod[31:0];
    endfunction

    function automatic wb_info_t make_wb(input logic wen, input preg_t rd, input word_t data);
        wb_info_t w;
        w.wen   = wen;
        w.rd    = rd;
        w.wdata = data;
        return w;
    endfunction

    function automatic wb_info_t get_wb(input int p);
        case (p)
            0: return wb_alu0;
            1: return wb_alu1;
            2: return wb_mdu;
            default: return wb_lsu;
        endcase
    endfunction

    function automatic alu_op_e to_alu_op(input string s);
        alu_op_e o;
        o = o.first();
        for (int i = 0; i < o.num(); i++) begin
            if (o.name() == s)
                return o;
            o = o.next();
        end
        $display("unknown ALU opcode %s in the case file", s);
        test_errs++;
        return ADD;
    endfunction

    task automatic check_wb(input string name, input wb_info_t exp, input wb_info_t act);
        if (act.wen !== exp.wen) begin
            $display("FAILED %s: wen expected %0b, actual %0b", name, exp.wen, act.wen);
            test_errs++;
        end else if (exp.wen && (act.rd !== exp.rd || act.wdata !== exp.wdata)) begin
            $display("FAILED %s: expected rd %0d data %h, actual rd %0d data %h",
                     name, exp.rd, exp.wdata, act.rd, act.wdata);
            test_errs++;
        end
    endtask

    task automatic check_ack(input string name, input logic exp, input logic act);
        if (act !== exp) begin
            $display("FAILED %s: mdu_ack expected %0b, actual %0b", name, exp, act);
            test_errs++;
        end
    endtask

    task automatic wait_wen(input int p, input string name, output wb_info_t w);
        int lat;
        lat = 1;
        w = get_wb(p);
        while (w.wen !== 1'b1 && lat < TIMEOUT) begin
            @(negedge clk);
            lat++;
            w = get_wb(p);
        end
        if (w.wen !== 1'b1) begin
            $display("%s: no write-back within %0d cycles", name, TIMEOUT);
            aborted = 1'b1;
        end else if (lat != 1) begin
            $display("%s: write-back came %0d cycles after issue instead of 1", name, lat);
            test_errs++;
        end
    endtask

    task automatic wait_ack(input logic level, input string name, output int cycles);
        cycles = 0;
        while (mdu_ack !== level && cycles < TIMEOUT) begin
            @(negedge clk);
            cycles++;
        end
        if (mdu_ack !== level) begin
            $display("%s: mdu_ack did not go to %0b within %0d cycles", name, level, TIMEOUT);
            aborted = 1'b1;
        end
    endtask

    task automatic run_alu(input string name, input int p, input alu_op_e op, input preg_t rs0,
                           input preg_t rs1, input preg_t rd, input logic [15:0] imm,
                           input bit have_exp, input word_t exp_val);
        alu_issue_t iss;
        wb_info_t   w;
        word_t      exp;
        exp = have_exp ? exp_val : alu_model(op, shadow[rs0], shadow[rs1], imm);
        iss = '{valid: 1'b1, op: op, rs0: rs0, rs1: rs1, rd: rd, imm: imm};
        @(negedge clk);
        if (p == 0)
            alu0_issue = iss;
        else
            alu1_issue = iss;
        @(negedge clk);
        alu0_issue = '0;
        alu1_issue = '0;
        wait_wen(p, name, w);
        if (!aborted) begin
            check_wb(name, make_wb(1'b1, rd, exp), w);
            if (rd != '0)
                shadow[rd] = exp;
        end
    endtask

    // alu0 loads rs1 with the immediate, alu1 reads it on the bypass
    task automatic run_pair(input string name, input alu_op_e op, input preg_t rs0,
                            input preg_t rs1, input preg_t rd, input logic [15:0] imm,
                            input bit have_exp, input word_t exp_val);
        alu_issue_t iss;
        wb_info_t   w;
        word_t      exp;
        @(negedge clk);
        alu0_issue = '{valid: 1'b1, op: ADDI, rs0: '0, rs1: '0, rd: rs1, imm: imm};
        @(negedge clk);
        iss = '{valid: 1'b1, op: op, rs0: rs0, rs1: rs1, rd: rd, imm: '0};
        alu0_issue = '0;
        alu1_issue = iss;
        check_wb({name, "/alu0"}, make_wb(1'b1, rs1, sext16(imm)), wb_alu0);
        if (rs1 != '0)
            shadow[rs1] = sext16(imm);
        exp = have_exp ? exp_val : alu_model(op, shadow[rs0], shadow[rs1], '0);
        @(negedge clk);
        alu1_issue = '0;
        wait_wen(1, name, w);
        if (!aborted) begin
            check_wb(name, make_wb(1'b1, rd, exp), w);
            if (rd != '0)
                shadow[rd] = exp;
        end
    endtask

    task automatic run_mdu(input string name, input mdu_op_e op, input preg_t rs0,
                           input preg_t rs1, input preg_t rd, input bit have_exp,
                           input word_t exp_val);
        word_t exp;
        int    cycles;
        exp = have_exp ? exp_val : mul_model(op, shadow[rs0], shadow[rs1]);
        @(negedge clk);
        mdu_req   = 1'b1;
        mdu_issue = '{op: op, rs0: rs0, rs1: rs1, rd: rd};
        wait_ack(1'b1, name, cycles);
        if (!aborted) begin
            check_wb(name, make_wb(1'b1, rd, exp), wb_mdu);   // Write-back rides with ack
            mdu_req = 1'b0;
            wait_ack(1'b0, name, cycles);
        end
        if (!aborted) begin
            if (cycles != 1) begin
                $display("%s: ack stayed high %0d cycles after req fell", name, cycles);
                test_errs++;
            end
            check_wb({name, "/after"}, make_wb(1'b0, '0, '0), wb_mdu);
            if (rd != '0)
                shadow[rd] = exp;
        end
    endtask

    task automatic run_lsu(input string name, input bit store, input preg_t base_r,
                           input preg_t data_r, input preg_t rd, input logic [15:0] off,
                           input bit have_exp, input word_t exp_val);
        logic [AW-1:0] addr;
        wb_info_t      w;
        word_t         exp;
        addr = AW'((shadow[base_r] + sext16(off)) % DRAM_DEPTH);
        @(negedge clk);
        lsu_issue = '{valid: 1'b1, op: store ? STORE : LOAD, base: base_r, data: data_r,
                      rd: rd, offset: off};
        @(negedge clk);
        lsu_issue = '0;
        if (store) begin
            check_wb(name, make_wb(1'b0, '0, '0), wb_lsu);
            mem_model[addr] = shadow[data_r];
        end else begin
            exp = have_exp ? exp_val : mem_model[addr];
            wait_wen(3, name, w);
            if (!aborted) begin
                check_wb(name, make_wb(1'b1, rd, exp), w);
                if (rd != '0)
                    shadow[rd] = exp;
            end
        end
    endtask

    task automatic finish_test(input string name);
        tests++;
        if (test_errs != 0 || aborted) begin
            failed_tests++;
            $display("[fail] %s", name);
        end else begin
            $display("[pass] %s", name);
        end
        test_errs = 0;
    endtask

    initial begin
        int          fd;
        int          n;
        int          rnd;
        int          rs0_i;
        int          rs1_i;
        int          rd_i;
        string       line;
        string       name;
        string       port;
        string       op_s;
        string       imm_s;
        string       exp_s;
        logic [15:0] imm;
        word_t       exp_val;
        bit          have_exp;

        clk        = 1'b0;
        rst        = 1'b1;
        alu0_issue = '0;
        alu1_issue = '0;
        mdu_req    = 1'b0;
        mdu_issue  = '0;
        lsu_issue  = '0;
        alu0_issue.valid = 1'b1;   // Issues held during reset must not write back
        alu1_issue.valid = 1'b1;
        lsu_issue.valid  = 1'b1;
        for (int r = 0; r < PREG_COUNT; r++)
            shadow[r] = '0;
        repeat (3) @(posedge clk);
        @(negedge clk);
        for (int p = 0; p < 4; p++)
            check_wb("reset_idle", make_wb(1'b0, '0, '0), get_wb(p));
        check_ack("reset_idle", 1'b0, mdu_ack);
        alu0_issue = '0;
        alu1_issue = '0;
        lsu_issue  = '0;
        rst        = 1'b0;
        finish_test("reset_idle");

        fd = $fopen("tb/exec_cases.txt", "r");
        if (fd == 0) begin
            $display("cannot open tb/exec_cases.txt");
            aborted = 1'b1;
        end else begin
            while (!aborted && !$feof(fd)) begin
                line = "";
                n = $fgets(line, fd);
                if (line.len() > 1 && line[0] != "#") begin
                    n = $sscanf(line, "%s %s %s %d %d %d %s %s",
                                name, port, op_s, rs0_i, rs1_i, rd_i, imm_s, exp_s);
                    if (n != 8) begin
                        $display("malformed line in case file: %s", line);
                        aborted = 1'b1;
                    end else begin
                        if (imm_s == "r") begin
                            rnd = $random(seed);
                            imm = rnd[15:0];
                        end else begin
                            n = $sscanf(imm_s, "%h", imm);
                        end
                        have_exp = (exp_s != "-");
                        exp_val  = '0;
                        if (have_exp)
                            n = $sscanf(exp_s, "%h", exp_val);
                        if (port == "alu0" || port == "alu1")
                            run_alu(name, (port == "alu0") ? 0 : 1, to_alu_op(op_s),
                                    preg_t'(rs0_i), preg_t'(rs1_i), preg_t'(rd_i), imm,
                                    have_exp, exp_val);
                        else if (port == "pair")
                            run_pair(name, to_alu_op(op_s), preg_t'(rs0_i), preg_t'(rs1_i),
                                     preg_t'(rd_i), imm, have_exp, exp_val);
                        else if (port == "mdu")
                            run_mdu(name, (op_s == "MUL_HI") ? MUL_HI : MUL_LO,
                                    preg_t'(rs0_i), preg_t'(rs1_i), preg_t'(rd_i),
                                    have_exp, exp_val);
                        else if (port == "lsu")
                            run_lsu(name, op_s == "STORE", preg_t'(rs0_i), preg_t'(rs1_i),
                                    preg_t'(rd_i), imm, have_exp, exp_val);
                        else begin
                            $display("unknown port %s in test %s", port, name);
                            test_errs++;
                        end
                        finish_test(name);
                    end
                end
            end
            $fclose(fd);
        end

        $display("tests: %0d, passed: %0d, failed: %0d",
                 tests, tests - failed_tests, failed_tests);
        if (failed_tests == 0 && !aborted)
            $display("Test OK");
        else
            $display("Test FAILED");
        $finish;
    end

endmodule

// ==== src/exec_cluster.sv ====
`timescale 1ns/1ps

module exec_cluster #(
    parameter int PREG_COUNT = 64,
    parameter int DRAM_DEPTH = 256
) (
    input  logic                    clk,
    input  logic                    rst,
    input  backend_pkg::alu_issue_t alu0_issue,
    input  backend_pkg::alu_issue_t alu1_issue,
    input  logic                    mdu_req,
    input  backend_pkg::mdu_issue_t mdu_issue,
    output logic                    mdu_ack,
    input  backend_pkg::lsu_issue_t lsu_issue,
    output backend_pkg::wb_info_t   wb_alu0,
    output backend_pkg::wb_info_t   wb_alu1,
    output backend_pkg::wb_info_t   wb_mdu,
    output backend_pkg::wb_info_t   wb_lsu
);
    import backend_pkg::*;

    prf_rnums_t rnum_alu0;
    prf_rnums_t rnum_alu1;
    prf_rnums_t rnum_mdu;
    prf_rnums_t rnum_lsu;
    prf_rdata_t rdata_alu0;
    prf_rdata_t rdata_alu1;
    prf_rdata_t rdata_mdu;
    prf_rdata_t rdata_lsu;

    prf #(
        .PREG_COUNT(PREG_COUNT)
    ) u_prf (
        .clk        (clk),
        .rst        (rst),
        .rnum_alu0  (rnum_alu0),
        .rnum_alu1  (rnum_alu1),
        .rnum_mdu   (rnum_mdu),
        .rnum_lsu   (rnum_lsu),
        .rdata_alu0 (rdata_alu0),
        .rdata_alu1 (rdata_alu1),
        .rdata_mdu  (rdata_mdu),
        .rdata_lsu  (rdata_lsu),
        .wb_alu0    (wb_alu0),
        .wb_alu1    (wb_alu1),
        .wb_mdu     (wb_mdu),
        .wb_lsu     (wb_lsu)
    );

    alu_pipe u_alu0 (
        .clk   (clk),
        .rst   (rst),
        .issue (alu0_issue),
        .rnum  (rnum_alu0),
        .rdata (rdata_alu0),
        .wb    (wb_alu0)
    );

    alu_pipe u_alu1 (
        .clk   (clk),
        .rst   (rst),
        .issue (alu1_issue),
        .rnum  (rnum_alu1),
        .rdata (rdata_alu1),
        .wb    (wb_alu1)
    );

    mdu_unit u_mdu (
        .clk   (clk),
        .rst   (rst),
        .req   (mdu_req),
        .issue (mdu_issue),
        .ack   (mdu_ack),
        .rnum  (rnum_mdu),
        .rdata (rdata_mdu),
        .wb    (wb_mdu)
    );

    lsu_unit #(
        .DRAM_DEPTH(DRAM_DEPTH)
    ) u_lsu (
        .clk   (clk),
        .rst   (rst),
        .issue (lsu_issue),
        .rnum  (rnum_lsu),
        .rdata (rdata_lsu),
        .wb    (wb_lsu)
    );

endmodule

// ==== src/lsu_unit.sv ====
`timescale 1ns/1ps

module lsu_unit #(
    parameter int DRAM_DEPTH = 256
) (
    input  logic                    clk,
    input  logic                    rst,
    input  backend_pkg::lsu_issue_t issue,
    output backend_pkg::prf_rnums_t rnum,
    input  backend_pkg::prf_rdata_t rdata,
    output backend_pkg::wb_info_t   wb
);
    import backend_pkg::*;

    localparam int AW = $clog2(DRAM_DEPTH);

    word_t         dram [DRAM_DEPTH];
    word_t         eff_addr;
    logic [AW-1:0] addr;
    logic          is_store;
    logic          is_load;

    // Base on rs0, store data on rs1
    assign rnum = '{rs0: issue.base, rs1: issue.data};

    assign eff_addr = rdata.rs0_data + {{16{issue.offset[15]}}, issue.offset};
    assign addr     = AW'(eff_addr % DRAM_DEPTH);   // Wraps around the RAM

    assign is_store = issue.valid && (issue.op == STORE);
    assign is_load  = issue.valid && (issue.op == LOAD);

    always_ff @(posedge clk) begin
        if (is_store)
            dram[addr] <= rdata.rs1_data;
    end

    always_ff @(posedge clk) begin
        wb.rd    <= issue.rd;
        wb.wdata <= dram[addr];
        if (rst)
            wb.wen <= 1'b0;
        else
            wb.wen <= is_load;   // No write-back for stores
    end

endmodule

// ==== src/mdu_unit.sv ====
`timescale 1ns/1ps

module mdu_unit (
    input  logic                    clk,
    input  logic                    rst,
    input  logic                    req,
    input  backend_pkg::mdu_issue_t issue,
    output logic                    ack,
    output backend_pkg::prf_rnums_t rnum,
    input  backend_pkg::prf_rdata_t rdata,
    output backend_pkg::wb_info_t   wb
);
    import backend_pkg::*;

    typedef enum logic [1:0] {
        IDLE,
        BUSY,
        DONE,
        WAIT_DROP
    } state_e;

    state_e      state;
    logic [4:0]  step;
    logic [63:0] acc;
    logic [63:0] mcand;
    word_t       mplier;
    mdu_op_e     op_q;
    preg_t       rd_q;
    logic        accept;

    assign rnum   = '{rs0: issue.rs0, rs1: issue.rs1};
    assign accept = (state == IDLE) && req;   // ack is low in IDLE

    always_ff @(posedge clk) begin
        if (rst) begin
            state <= IDLE;
            step  <= '0;
        end else begin
            case (state)
                IDLE: begin
                    if (req) begin
                        state <= BUSY;
                        step  <= '0;
                    end
                end
                BUSY: begin
                    step <= step + 5'd1;
                    if (step == 5'd31)
                        state <= DONE;
                end
                DONE: state <= req ? WAIT_DROP : IDLE;
                WAIT_DROP: begin
                    if (!req)
                        state <= IDLE;
                end
                default: state <= IDLE;
            endcase
        end
    end

    // Shift-add, one multiplier bit per cycle
    always_ff @(posedge clk) begin
        if (accept) begin
            acc    <= '0;
            mcand  <= {32'b0, rdata.rs0_data};
            mplier <= rdata.rs1_data;
            op_q   <= issue.op;
            rd_q   <= issue.rd;
        end else if (state == BUSY) begin
            acc    <= acc + (mplier[0] ? mcand : 64'b0);
            mcand  <= mcand << 1;
            mplier <= mplier >> 1;
        end
    end

    assign ack = (state == DONE) || (state == WAIT_DROP);

    assign wb = '{
        wen:   state == DONE,
        rd:    rd_q,
        wdata: (op_q == MUL_HI) ? acc[63:32] : acc[31:0]
    };

    a_req_held: assert property (@(posedge clk) disable iff (rst) state == BUSY |-> req)
        else $error("mdu_unit: req dropped during multiply");

endmodule

// ==== src/alu_pipe.sv ====
`timescale 1ns/1ps

module alu_pipe (
    input  logic                    clk,
    input  logic                    rst,
    input  backend_pkg::alu_issue_t issue,
    output backend_pkg::prf_rnums_t rnum,
    input  backend_pkg::prf_rdata_t rdata,
    output backend_pkg::wb_info_t   wb
);
    import backend_pkg::*;

    word_t src0;
    word_t src1;
    word_t imm_ext;
    word_t result;

    assign rnum = '{rs0: issue.rs0, rs1: issue.rs1};

    assign src0    = rdata.rs0_data;
    assign src1    = rdata.rs1_data;
    assign imm_ext = {{16{issue.imm[15]}}, issue.imm};

    always_comb begin
        case (issue.op)
            ADD:  result = src0 + src1;
            SUB:  result = src0 - src1;
            AND:  result = src0 & src1;
            OR:   result = src0 | src1;
            XOR:  result = src0 ^ src1;
            SLL:  result = src0 << src1[4:0];
            SRL:  result = src0 >> src1[4:0];
            SLT:  result = {31'b0, $signed(src0) < $signed(src1)};
            ADDI: result = src0 + imm_ext;   // Source 1 unused
            default: result = '0;
        endcase
    end

    // Result visible on the write-back port one cycle after issue
    always_ff @(posedge clk) begin
        wb.rd    <= issue.rd;
        wb.wdata <= result;
        if (rst)
            wb.wen <= 1'b0;
        else
            wb.wen <= issue.valid;
    end

endmodule

// ==== src/prf.sv ====
`timescale 1ns/1ps

module prf #(
    parameter int PREG_COUNT = 64
) (
    input  logic                    clk,
    input  logic                    rst,
    input  backend_pkg::prf_rnums_t rnum_alu0,
    input  backend_pkg::prf_rnums_t rnum_alu1,
    input  backend_pkg::prf_rnums_t rnum_mdu,
    input  backend_pkg::prf_rnums_t rnum_lsu,
    output backend_pkg::prf_rdata_t rdata_alu0,
    output backend_pkg::prf_rdata_t rdata_alu1,
    output backend_pkg::prf_rdata_t rdata_mdu,
    output backend_pkg::prf_rdata_t rdata_lsu,
    input  backend_pkg::wb_info_t   wb_alu0,
    input  backend_pkg::wb_info_t   wb_alu1,
    input  backend_pkg::wb_info_t   wb_mdu,
    input  backend_pkg::wb_info_t   wb_lsu
);
    import backend_pkg::*;

    localparam int PORTS = 4;

    // One replicated bank per read port
    word_t bank [PORTS][PREG_COUNT];

    prf_rnums_t          rnum   [PORTS];
    prf_rdata_t          rdata  [PORTS];
    wb_info_t [PORTS-1:0] wb_all;   // Index order is bypass priority
    logic                wb_clash;

    assign rnum[0] = rnum_alu0;
    assign rnum[1] = rnum_alu1;
    assign rnum[2] = rnum_mdu;
    assign rnum[3] = rnum_lsu;

    assign rdata_alu0 = rdata[0];
    assign rdata_alu1 = rdata[1];
    assign rdata_mdu  = rdata[2];
    assign rdata_lsu  = rdata[3];

    assign wb_all = {wb_lsu, wb_mdu, wb_alu1, wb_alu0};

    // Zero register, then first matching write-back, then bank
    function automatic word_t read_src(input preg_t r, input word_t bank_val,
                                       input wb_info_t [PORTS-1:0] wbs);
        word_t val;
        val = bank_val;
        for (int i = PORTS - 1; i >= 0; i--) begin   // Lowest index wins
            if (wbs[i].wen && wbs[i].rd == r)
                val = wbs[i].wdata;
        end
        if (r == '0)
            val = '0;
        return val;
    endfunction

    for (genvar k = 0; k < PORTS; k++) begin : g_read
        assign rdata[k] = '{
            rs0_data: read_src(rnum[k].rs0, bank[k][rnum[k].rs0], wb_all),
            rs1_data: read_src(rnum[k].rs1, bank[k][rnum[k].rs1], wb_all)
        };
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            for (int k = 0; k < PORTS; k++) begin
                for (int r = 0; r < PREG_COUNT; r++)
                    bank[k][r] <= '0;
            end
        end else begin
            for (int i = 0; i < PORTS; i++) begin
                if (wb_all[i].wen && wb_all[i].rd != '0) begin
                    for (int k = 0; k < PORTS; k++)
                        bank[k][wb_all[i].rd] <= wb_all[i].wdata;
                end
            end
        end
    end

    always_comb begin
        wb_clash = 1'b0;
        for (int i = 0; i < PORTS; i++) begin
            for (int j = i + 1; j < PORTS; j++) begin
                if (wb_all[i].wen && wb_all[j].wen && wb_all[i].rd == wb_all[j].rd
                    && wb_all[i].rd != '0)
                    wb_clash = 1'b1;
            end
        end
    end

    // Scheduler must never send two units to one destination at once
    a_wb_unique: assert property (@(posedge clk) disable iff (rst) !wb_clash)
        else $error("prf: two write-backs to one register in a cycle");

endmodule

// ==== src/backend_pkg.sv ====
package backend_pkg;

    localparam int DATA_W = 32;
    localparam int PREG_W = 6;

    typedef logic [PREG_W-1:0] preg_t;
    typedef logic [DATA_W-1:0] word_t;

    typedef enum logic [3:0] {
        ADD,
        SUB,
        AND,
        OR,
        XOR,
        SLL,
        SRL,
        SLT,   // Signed compare
        ADDI   // Source 0 plus immediate
    } alu_op_e;

    typedef enum logic {
        MUL_LO,
        MUL_HI
    } mdu_op_e;

    typedef enum logic {
        LOAD,
        STORE
    } lsu_op_e;

    typedef struct packed {
        preg_t rs0;
        preg_t rs1;
    } prf_rnums_t;

    typedef struct packed {
        word_t rs0_data;
        word_t rs1_data;
    } prf_rdata_t;

    typedef struct packed {
        logic  wen;
        preg_t rd;
        word_t wdata;
    } wb_info_t;

    typedef struct packed {
        logic        valid;
        alu_op_e     op;
        preg_t       rs0;
        preg_t       rs1;
        preg_t       rd;
        logic [15:0] imm;   // Sign-extended in the ALU
    } alu_issue_t;

    typedef struct packed {
        mdu_op_e op;
        preg_t   rs0;
        preg_t   rs1;
        preg_t   rd;
    } mdu_issue_t;

    typedef struct packed {
        logic        valid;
        lsu_op_e     op;
        preg_t       base;
        preg_t       data;    // Store source
        preg_t       rd;
        logic [15:0] offset;  // Word offset from base
    } lsu_issue_t;

endpackage
